// ==== logic/nkmd_pkg.sv ====
package nkmd_pkg;

    localparam int xlen = 32;
    localparam int regsel_w = 4;
    localparam int alusel_w = 3;
    localparam int mwsel_w = 2;
    localparam int num_regs = 13;

    // Instruction field positions
    localparam int f_jmp_en = 31;
    localparam int f_mwsel = 29;
    localparam int f_r_read = 28;
    localparam int f_rd = 24;
    localparam int f_alu = 21;
    localparam int f_rs = 17;
    localparam int f_imm_en = 16;
    localparam int f_sign = 15;
    localparam int f_imm = 0;
    localparam int imm_low_w = 15;
    localparam int f_rt = 8;
    localparam int f_jmp_off = 0;
    localparam int jmp_off_w = 8;

    typedef logic [xlen-1:0] word_t;
    typedef logic [regsel_w-1:0] regsel_t;

    typedef enum logic [alusel_w-1:0] {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_or    = 3'd2,
        op_and   = 3'd3,
        op_xor   = 3'd4,
        op_resv  = 3'd5,
        op_clamp = 3'd6,
        op_mul   = 3'd7
    } alusel_t;

    // mw_t and mw_c have no target in this core
    typedef enum logic [mwsel_w-1:0] {
        mw_reg = 2'd0,
        mw_r   = 2'd1,
        mw_t   = 2'd2,
        mw_c   = 2'd3
    } mwsel_t;

    // Fixed select codes, read as zero
    localparam regsel_t reg_zero = 4'h0;
    localparam regsel_t reg_ra = 4'hb;
    localparam regsel_t reg_pc = 4'hf;

    typedef struct packed {
        regsel_t rssel;
        regsel_t rtsel;
        regsel_t rdsel;
        alusel_t alusel;
        word_t   imm;
        word_t   jmprel;
        logic    r_read_en;
        mwsel_t  mwsel;
        logic    imm_en;
        logic    jmp_en;
    } decoded_t;

    typedef struct packed {
        word_t   sval;
        word_t   tval;
        alusel_t alusel;
        regsel_t rdsel;
        word_t   rdval;
        word_t   jmprel;
        mwsel_t  mwsel;
        logic    jmp_en;
    } operands_t;

    typedef struct packed {
        regsel_t rdsel;
        word_t   val;
        word_t   rdval;
        mwsel_t  mwsel;
    } ex_result_t;

endpackage

// ==== logic/nkmd_fetch.sv ====
module nkmd_fetch
    import nkmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  jmp_en_i,
    input  word_t jmp_pc_i,
    output word_t p_addr_o
);

    word_t pc;

    // Jump target from execute wins over the increment
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (jmp_en_i) begin
            pc <= jmp_pc_i;
        end else begin
            pc <= pc + word_t'(1);
        end
    end

    assign p_addr_o = pc;

endmodule

// ==== logic/nkmd_decode.sv ====
module nkmd_decode
    import nkmd_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  word_t    inst_i,
    output decoded_t dcd_o
);

    decoded_t dcd_q;

    function automatic decoded_t decode(word_t inst);
        decoded_t d;
        logic jmp;
        jmp = inst[f_jmp_en];
        d.rssel = inst[f_rs +: regsel_w];
        d.rtsel = inst[f_rt +: regsel_w];
        d.rdsel = inst[f_rd +: regsel_w];
        d.alusel = alusel_t'(inst[f_alu +: alusel_w]);
        // Both fields share the sign bit at 15
        d.imm = {{(xlen - imm_low_w){inst[f_sign]}}, inst[f_imm +: imm_low_w]};
        d.jmprel = {{(xlen - jmp_off_w){inst[f_sign]}}, inst[f_jmp_off +: jmp_off_w]};
        // No bus R traffic on a jump
        d.r_read_en = !jmp && inst[f_r_read];
        d.mwsel = jmp ? mw_reg : mwsel_t'(inst[f_mwsel +: mwsel_w]);
        d.imm_en = inst[f_imm_en];
        d.jmp_en = jmp;
        return d;
    endfunction

    // Output stays zero through the first cycle after reset,
    // so the first decoded word is the one at address 0
    always_ff @(posedge clk) begin
        if (rst) begin
            dcd_q <= '0;
        end else begin
            dcd_q <= decode(inst_i);
        end
    end

    assign dcd_o = dcd_q;

endmodule

// ==== logic/nkmd_regfile.sv ====
module nkmd_regfile
    import nkmd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  decoded_t   dcd_i,
    input  ex_result_t wb_i,
    output word_t      rsval_o,
    output word_t      rtval_o,
    output word_t      rdval_o
);

    word_t regs [num_regs];

    function automatic logic is_fixed(regsel_t sel);
        return sel == reg_zero || sel == reg_ra || sel == reg_pc;
    endfunction

    // Codes 1..a map to slots 0..9, c..e to 10..12
    function automatic regsel_t slot(regsel_t sel);
        return (sel > reg_ra) ? sel - regsel_t'(2) : sel - regsel_t'(1);
    endfunction

    always_comb begin
        rsval_o = is_fixed(dcd_i.rssel) ? '0 : regs[slot(dcd_i.rssel)];
        rtval_o = is_fixed(dcd_i.rtsel) ? '0 : regs[slot(dcd_i.rtsel)];
        rdval_o = is_fixed(dcd_i.rdsel) ? '0 : regs[slot(dcd_i.rdsel)];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.mwsel == mw_reg && !is_fixed(wb_i.rdsel)) begin
            regs[slot(wb_i.rdsel)] <= wb_i.val;
        end
    end

endmodule

// ==== logic/nkmd_mem_stage.sv ====
module nkmd_mem_stage
    import nkmd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  decoded_t   dcd_i,
    input  word_t      rsval_i,
    input  word_t      rtval_i,
    input  word_t      rdval_i,
    input  ex_result_t wb_i,
    input  word_t      r_data_i,
    output word_t      r_addr_o,
    output word_t      r_data_o,
    output logic       r_we_o,
    output operands_t  ops_o
);

    word_t     eff_addr;
    logic      wb_r_write;
    operands_t ops_q;
    logic      r_read_q;

    assign eff_addr = dcd_i.imm_en ? dcd_i.imm : rtval_i;

    // Writeback takes the bus over the read of the younger instruction
    assign wb_r_write = wb_i.mwsel == mw_r;
    assign r_addr_o = wb_r_write ? wb_i.rdval : eff_addr;
    assign r_data_o = wb_i.val;
    assign r_we_o = wb_r_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            ops_q <= '0;
            r_read_q <= 1'b0;
        end else begin
            ops_q.sval <= rsval_i;
            ops_q.tval <= eff_addr;
            ops_q.alusel <= dcd_i.alusel;
            ops_q.rdsel <= dcd_i.rdsel;
            ops_q.rdval <= rdval_i;
            ops_q.jmprel <= dcd_i.jmprel;
            ops_q.mwsel <= dcd_i.mwsel;
            ops_q.jmp_en <= dcd_i.jmp_en;
            r_read_q <= dcd_i.r_read_en;
        end
    end

    // Read data arrives one cycle after the address
    always_comb begin
        ops_o = ops_q;
        if (r_read_q) begin
            ops_o.tval = r_data_i;
        end
    end

endmodule

// ==== logic/nkmd_execute.sv ====
module nkmd_execute
    import nkmd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  operands_t  ops_i,
    output ex_result_t ex_o,
    output logic       jmp_en_o,
    output word_t      jmp_pc_o
);

    word_t      alu_val;
    ex_result_t ex_q;
    logic       jmp_en_q;
    word_t      jmp_pc_q;

    always_comb begin
        case (ops_i.alusel)
            op_add:  alu_val = ops_i.sval + ops_i.tval;
            op_sub:  alu_val = ops_i.sval - ops_i.tval;
            op_or:   alu_val = ops_i.sval | ops_i.tval;
            op_and:  alu_val = ops_i.sval & ops_i.tval;
            op_xor:  alu_val = ops_i.sval ^ ops_i.tval;
            // resv, clamp and mul are not implemented
            default: alu_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q <= '0;
            jmp_en_q <= 1'b0;
            jmp_pc_q <= '0;
        end else begin
            ex_q.rdsel <= ops_i.rdsel;
            ex_q.val <= alu_val;
            ex_q.rdval <= ops_i.rdval;
            ex_q.mwsel <= ops_i.mwsel;
            jmp_en_q <= ops_i.jmp_en;
            // Relative to the rd register
            jmp_pc_q <= ops_i.rdval + ops_i.jmprel;
        end
    end

    assign ex_o = ex_q;
    assign jmp_en_o = jmp_en_q;
    assign jmp_pc_o = jmp_pc_q;

endmodule

// ==== logic/nkmd_cpu.sv ====
module nkmd_cpu
    import nkmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t p_data_i,
    output word_t p_addr_o,
    input  word_t r_data_i,
    output word_t r_data_o,
    output word_t r_addr_o,
    output logic  r_we_o
);

    decoded_t   dcd;
    word_t      rsval;
    word_t      rtval;
    word_t      rdval;
    operands_t  ops;
    ex_result_t ex;
    logic       jmp_en;
    word_t      jmp_pc;

    nkmd_fetch nkmd_fetch_inst (
        .clk      (clk),
        .rst      (rst),
        .jmp_en_i (jmp_en),
        .jmp_pc_i (jmp_pc),
        .p_addr_o (p_addr_o)
    );

    // Program bus answers in the same cycle
    nkmd_decode nkmd_decode_inst (
        .clk    (clk),
        .rst    (rst),
        .inst_i (p_data_i),
        .dcd_o  (dcd)
    );

    nkmd_regfile nkmd_regfile_inst (
        .clk     (clk),
        .rst     (rst),
        .dcd_i   (dcd),
        .wb_i    (ex),
        .rsval_o (rsval),
        .rtval_o (rtval),
        .rdval_o (rdval)
    );

    nkmd_mem_stage nkmd_mem_stage_inst (
        .clk      (clk),
        .rst      (rst),
        .dcd_i    (dcd),
        .rsval_i  (rsval),
        .rtval_i  (rtval),
        .rdval_i  (rdval),
        .wb_i     (ex),
        .r_data_i (r_data_i),
        .r_addr_o (r_addr_o),
        .r_data_o (r_data_o),
        .r_we_o   (r_we_o),
        .ops_o    (ops)
    );

    nkmd_execute nkmd_execute_inst (
        .clk      (clk),
        .rst      (rst),
        .ops_i    (ops),
        .ex_o     (ex),
        .jmp_en_o (jmp_en),
        .jmp_pc_o (jmp_pc)
    );

endmodule

// ==== dv/nkmd_cpu_properties.sv ====
module nkmd_cpu_properties
    import nkmd_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input word_t p_addr_o,
    input logic  r_we_o,
    input logic  jmp_en_i
);

    // No bus R write while the pipeline is flushed by reset
    assert property (@(posedge clk) rst |=> !r_we_o ##1 !r_we_o)
        else $error("r_we_o high during or right after reset");

    assert property (@(posedge clk) $fell(rst) |-> p_addr_o == '0)
        else $error("p_addr_o not zero after reset");

    // Sequential fetch unless a jump was taken
    assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && !$past(jmp_en_i) |-> p_addr_o == $past(p_addr_o) + word_t'(1))
        else $error("p_addr_o did not increment");

endmodule

bind nkmd_cpu nkmd_cpu_properties nkmd_cpu_properties_inst (
    .clk      (clk),
    .rst      (rst),
    .p_addr_o (p_addr_o),
    .r_we_o   (r_we_o),
    .jmp_en_i (jmp_en)
);

// ==== dv/nkmd_cpu_tb.sv ====
module nkmd_cpu_tb
    import nkmd_pkg::*;
();

    localparam int prog_words = 128;
    localparam int num_tests = 5;
    localparam int watchdog_time = num_tests * (prog_words + 20) * 20 * 2;
    localparam regsel_t addr_reg = 4'hc;

    logic  clk;
    logic  rst;
    word_t p_data_i;
    word_t p_addr_o;
    word_t r_data_i;
    word_t r_data_o;
    word_t r_addr_o;
    logic  r_we_o;

    word_t prog [prog_words];
    word_t ram [256];
    word_t rd_q;
    int    plen;
    word_t seed;
    word_t wr_addr [$];
    word_t wr_data [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    addr_errs;
    int    data_errs;
    int    other_errs;

    nkmd_cpu nkmd_cpu_inst (
        .clk      (clk),
        .rst      (rst),
        .p_data_i (p_data_i),
        .p_addr_o (p_addr_o),
        .r_data_i (r_data_i),
        .r_data_o (r_data_o),
        .r_addr_o (r_addr_o),
        .r_we_o   (r_we_o)
    );

    always #10 clk = ~clk;

    assign p_data_i = prog[p_addr_o[6:0]];

    // RAM model with one cycle of read latency
    always @(negedge clk) begin
        if (r_we_o) begin
            ram[r_addr_o[7:0]] = r_data_o;
            wr_addr.push_back(r_addr_o);
            wr_data.push_back(r_data_o);
        end
        r_data_i <= rd_q;
        rd_q <= ram[r_addr_o[7:0]];
    end

    function automatic word_t xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic word_t sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t encode_inst(logic jmp, mwsel_t mw, logic rread, regsel_t rd,
                                          alusel_t alu, regsel_t rs, logic imm_en,
                                          logic [15:0] low);
        return {jmp, mw, rread, rd, alu, rs, imm_en, low};
    endfunction

    function automatic word_t load_imm_inst(regsel_t rd, logic [15:0] v);
        return encode_inst(1'b0, mw_reg, 1'b0, rd, op_add, reg_zero, 1'b1, v);
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %08h expected %08h", name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_addr(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %08h expected %08h", name, got, exp);
            addr_errs++;
        end
    endtask

    // Three NOPs keep dependent instructions apart
    task automatic put(word_t w);
        prog[plen] = w;
        prog[plen + 1] = '0;
        prog[plen + 2] = '0;
        prog[plen + 3] = '0;
        plen += 4;
    endtask

    task automatic store_to(logic [15:0] addr, regsel_t src, word_t exp);
        put(load_imm_inst(addr_reg, addr));
        put(encode_inst(1'b0, mw_r, 1'b0, addr_reg, op_add, src, 1'b1, 16'h0));
        exp_addr.push_back(sext16(addr));
        exp_data.push_back(exp);
    endtask

    task automatic new_program();
        for (int i = 0; i < prog_words; i++) begin
            prog[i] = '0;
        end
        plen = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic wait_addr(word_t addr, int limit);
        int cycles;
        cycles = 0;
        while (p_addr_o !== addr && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (p_addr_o !== addr) begin
            $display("Fetch never reached address %08h", addr);
            other_errs++;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        wr_addr.delete();
        wr_data.delete();
        rst = 1'b0;
    endtask

    task automatic run_and_compare(string test);
        wait_addr(word_t'(plen), plen + 8);
        // Drain the pipeline behind the last instruction
        repeat (6) @(negedge clk);
        if (wr_addr.size() != exp_addr.size()) begin
            $display("%s: %0d bus R writes seen, %0d expected", test, wr_addr.size(),
                     exp_addr.size());
            other_errs++;
        end else begin
            for (int i = 0; i < exp_addr.size(); i++) begin
                check_addr("r_addr_o", wr_addr[i], exp_addr[i]);
                check_word("r_data_o", wr_data[i], exp_data[i]);
            end
        end
    endtask

    task automatic test_imm_store();
        logic [15:0] v [4];
        new_program();
        for (int i = 0; i < 4; i++) begin
            v[i] = 16'(xorshift());
            put(load_imm_inst(regsel_t'(i + 1), v[i]));
        end
        for (int i = 0; i < 4; i++) begin
            store_to(16'h0040 + 16'(i), regsel_t'(i + 1), sext16(v[i]));
        end
        reset_dut();
        run_and_compare("imm_store");
    endtask

    task automatic test_alu();
        word_t a;
        word_t b;
        word_t exp;
        new_program();
        a = sext16(16'(xorshift()));
        b = sext16(16'(xorshift()));
        put(load_imm_inst(4'h1, a[15:0]));
        put(load_imm_inst(4'h2, b[15:0]));
        for (int op = 0; op < 8; op++) begin
            case (op)
                0: exp = a + b;
                1: exp = a - b;
                2: exp = a | b;
                3: exp = a & b;
                4: exp = a ^ b;
                default: exp = '0;
            endcase
            put(encode_inst(1'b0, mw_reg, 1'b0, 4'h3, alusel_t'(op), 4'h1, 1'b0, 16'h0200));
            store_to(16'h0050 + 16'(op), 4'h3, exp);
        end
        reset_dut();
        run_and_compare("alu");
    endtask

    task automatic test_bus_load();
        word_t v0;
        word_t v1;
        new_program();
        v0 = xorshift();
        v1 = xorshift();
        ram[8'h10] = v0;
        ram[8'h21] = v1;
        put(encode_inst(1'b0, mw_reg, 1'b1, 4'h1, op_add, reg_zero, 1'b1, 16'h0010));
        put(load_imm_inst(4'h2, 16'h0021));
        // Address from rt = r2
        put(encode_inst(1'b0, mw_reg, 1'b1, 4'h3, op_add, reg_zero, 1'b0, 16'h0200));
        store_to(16'h0060, 4'h1, v0);
        store_to(16'h0061, 4'h3, v1);
        reset_dut();
        run_and_compare("bus_load");
    endtask

    task automatic test_jump();
        logic [15:0] v [3];
        new_program();
        put(load_imm_inst(4'h5, 16'h0030));
        // Offset f0 with the sign bit set, 0x30 - 0x10 lands on 32
        prog[4] = encode_inst(1'b1, mw_r, 1'b1, 4'h5, op_add, reg_zero, 1'b0, 16'h80f0);
        for (int i = 0; i < 3; i++) begin
            v[i] = 16'(xorshift());
            prog[5 + i] = load_imm_inst(regsel_t'(i + 1), v[i]);
        end
        for (int i = 8; i < 32; i++) begin
            prog[i] = load_imm_inst(4'h4, 16'h0bad);
        end
        plen = 32;
        put('0);
        for (int i = 0; i < 3; i++) begin
            store_to(16'h0030 + 16'(i), regsel_t'(i + 1), sext16(v[i]));
        end
        store_to(16'h0033, 4'h4, '0);
        reset_dut();
        wait_addr(word_t'(7), 16);
        @(negedge clk);
        check_addr("p_addr_o", p_addr_o, word_t'(32));
        run_and_compare("jump");
    endtask

    task automatic test_special_sel();
        new_program();
        put(load_imm_inst(4'h1, 16'h1234));
        put(load_imm_inst(reg_zero, 16'h5555));
        put(load_imm_inst(reg_ra, 16'h5555));
        put(load_imm_inst(reg_pc, 16'h5555));
        put(encode_inst(1'b0, mw_t, 1'b0, 4'h1, op_add, reg_zero, 1'b1, 16'h0777));
        put(encode_inst(1'b0, mw_c, 1'b0, 4'h1, op_add, reg_zero, 1'b1, 16'h0777));
        store_to(16'h0070, reg_zero, '0);
        store_to(16'h0071, reg_ra, '0);
        store_to(16'h0072, reg_pc, '0);
        store_to(16'h0073, 4'h1, word_t'(32'h1234));
        reset_dut();
        run_and_compare("special_sel");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        r_data_i = '0;
        rd_q = '0;
        seed = word_t'(15660);
        addr_errs = 0;
        data_errs = 0;
        other_errs = 0;
        for (int i = 0; i < 256; i++) begin
            ram[i] = word_t'(i) * word_t'(32'h01010101) ^ word_t'(32'h5a000000);
        end
        new_program();
        test_imm_store();
        test_alu();
        test_bus_load();
        test_jump();
        test_special_sel();
        $display("Errors: address %0d, data %0d, other %0d", addr_errs, data_errs,
                 other_errs);
        if (addr_errs + data_errs + other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== build.f ====
logic/nkmd_pkg.sv
logic/nkmd_fetch.sv
logic/nkmd_decode.sv
logic/nkmd_regfile.sv
logic/nkmd_mem_stage.sv
logic/nkmd_execute.sv
logic/nkmd_cpu.sv
dv/nkmd_cpu_properties.sv
dv/nkmd_cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= nkmd_cpu_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "All tests passed!" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
